// File: common/bev_pkg.sv
package bev_pkg;

    // ingredient amounts
    localparam int ING_W = 12;
    localparam int N_ING = 4;        // black tea, green tea, milk, pineapple
    localparam int SUP_CNT_W = 3;    // counts 0..4 supply strobes

    typedef logic [ING_W-1:0] ing_amt_t;

    localparam ing_amt_t ING_MAX = ing_amt_t'(4095);

    // box record in external memory
    localparam int REC_W = 64;
    localparam int REC_DATE_W = 8;   // month and day fields are byte wide in the record

    typedef logic [REC_W-1:0] box_rec_t;

    localparam int unsigned REC_BLACK_LSB = 52;
    localparam int unsigned REC_GREEN_LSB = 40;
    localparam int unsigned REC_MONTH_LSB = 32;
    localparam int unsigned REC_MILK_LSB = 20;
    localparam int unsigned REC_PINE_LSB = 8;
    localparam int unsigned REC_DAY_LSB = 0;

    // same order as the supply strobes
    localparam int unsigned ING_LSB [N_ING] = '{REC_BLACK_LSB, REC_GREEN_LSB,
                                                REC_MILK_LSB, REC_PINE_LSB};

    typedef logic [7:0] box_no_t;
    typedef logic [3:0] month_t;
    typedef logic [4:0] day_t;

    typedef enum logic [1:0] {
        ACT_MAKE   = 2'd0,
        ACT_SUPPLY = 2'd1,
        ACT_CHECK  = 2'd2
    } action_t;

    typedef enum logic [2:0] {
        BEV_BLACK_TEA           = 3'd0,
        BEV_MILK_TEA            = 3'd1,
        BEV_EXTRA_MILK_TEA      = 3'd2,
        BEV_GREEN_TEA           = 3'd3,
        BEV_GREEN_MILK_TEA      = 3'd4,
        BEV_PINE_JUICE          = 3'd5,
        BEV_SUPER_PINE_TEA      = 3'd6,
        BEV_SUPER_PINE_MILK_TEA = 3'd7
    } bev_type_t;

    typedef enum logic [1:0] {
        SIZE_L = 2'd0,
        SIZE_M = 2'd1,
        SIZE_S = 2'd3    // code 2 unused
    } bev_size_t;

    typedef enum logic [1:0] {
        ERR_NONE     = 2'd0,
        ERR_EXPIRED  = 2'd1,
        ERR_NO_ING   = 2'd2,
        ERR_OVERFLOW = 2'd3
    } err_t;

    // cup volumes
    localparam ing_amt_t VOL_L = ing_amt_t'(960);
    localparam ing_amt_t VOL_M = ing_amt_t'(720);
    localparam ing_amt_t VOL_S = ing_amt_t'(480);

    typedef enum logic [2:0] {
        S_IDLE,
        S_COLLECT,   // gathering strobes for the action
        S_READ,      // read issued, waiting on memory
        S_WRITE,     // write-back issued
        S_DONE
    } ctrl_state_t;

endpackage

// File: design/bev_input_capture.sv
`timescale 1ns/100ps

module bev_input_capture import bev_pkg::*; (
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  sel_action_valid,
    input  action_t               act,
    input  logic                  type_valid,
    input  bev_type_t             bev_type,
    input  logic                  size_valid,
    input  bev_size_t             bev_size,
    input  logic                  date_valid,
    input  month_t                month,
    input  day_t                  day,
    input  logic                  box_no_valid,
    input  box_no_t               box_no,
    input  logic                  box_sup_valid,
    input  ing_amt_t              ing,
    output action_t               cur_act,
    output bev_type_t             cur_type,
    output bev_size_t             cur_size,
    output month_t                today_month,
    output day_t                  today_day,
    output box_no_t               cur_box,
    output ing_amt_t              sup_amt [N_ING],
    output logic [SUP_CNT_W-1:0]  sup_count
);

    // action and supply count steer the controller
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            cur_act   <= ACT_MAKE;
            sup_count <= '0;
        end else begin
            if (sel_action_valid)
                cur_act <= act;
            if (sel_action_valid)
                sup_count <= '0;    // new transaction
            else if (box_sup_valid && sup_count != SUP_CNT_W'(N_ING))
                sup_count <= sup_count + 1'b1;   // stops at four
        end
    end

    // transaction fields, held until the next strobe
    always_ff @(posedge clk) begin
        if (type_valid)
            cur_type <= bev_type;
        if (size_valid)
            cur_size <= bev_size;
        if (date_valid) begin
            today_month <= month;
            today_day   <= day;
        end
        if (box_no_valid)
            cur_box <= box_no;
    end

    // supply amounts shift in from the top, so black tea ends in entry 0
    always_ff @(posedge clk) begin
        if (box_sup_valid) begin
            for (int i = 0; i < N_ING - 1; i++)
                sup_amt[i] <= sup_amt[i+1];
            sup_amt[N_ING-1] <= ing;
        end
    end

endmodule

// File: design/bev_recipe.sv
`timescale 1ns/100ps

module bev_recipe import bev_pkg::*; (
    input  bev_type_t cur_type,
    input  bev_size_t cur_size,
    output ing_amt_t  use_black,
    output ing_amt_t  use_green,
    output ing_amt_t  use_milk,
    output ing_amt_t  use_pine
);

    ing_amt_t vol;        // whole cup
    ing_amt_t vol_half;
    ing_amt_t vol_qtr;
    ing_amt_t vol_3q;

    always_comb begin
        case (cur_size)
            SIZE_L:  vol = VOL_L;
            SIZE_M:  vol = VOL_M;
            SIZE_S:  vol = VOL_S;
            default: vol = '0;    // unused size code uses nothing
        endcase
    end

    // all cup volumes divide evenly by four
    assign vol_half = vol >> 1;
    assign vol_qtr  = vol >> 2;
    assign vol_3q   = vol - vol_qtr;

    always_comb begin
        use_black = '0;
        use_green = '0;
        use_milk  = '0;
        use_pine  = '0;
        case (cur_type)
            BEV_BLACK_TEA:      use_black = vol;
            BEV_MILK_TEA: begin              // 3:1 tea to milk
                use_black = vol_3q;
                use_milk  = vol_qtr;
            end
            BEV_EXTRA_MILK_TEA: begin
                use_black = vol_half;
                use_milk  = vol_half;
            end
            BEV_GREEN_TEA:      use_green = vol;
            BEV_GREEN_MILK_TEA: begin
                use_green = vol_half;
                use_milk  = vol_half;
            end
            BEV_PINE_JUICE:     use_pine = vol;
            BEV_SUPER_PINE_TEA: begin
                use_black = vol_half;
                use_pine  = vol_half;
            end
            BEV_SUPER_PINE_MILK_TEA: begin   // 2:1:1
                use_black = vol_half;
                use_milk  = vol_qtr;
                use_pine  = vol_qtr;
            end
            default: ;
        endcase
    end

endmodule

// File: design/bev_record_eval.sv
`timescale 1ns/100ps

module bev_record_eval import bev_pkg::*; (
    input  box_rec_t  rec,
    input  action_t   cur_act,
    input  month_t    today_month,
    input  day_t      today_day,
    input  ing_amt_t  sup_amt [N_ING],
    input  ing_amt_t  use_black,
    input  ing_amt_t  use_green,
    input  ing_amt_t  use_milk,
    input  ing_amt_t  use_pine,
    output box_rec_t  new_rec,
    output err_t      result,
    output logic      needs_write
);

    ing_amt_t               have_amt [N_ING];   // amounts in the box
    ing_amt_t               use_amt  [N_ING];
    logic [ING_W:0]         sum_amt  [N_ING];   // one extra bit for carry
    logic [REC_DATE_W-1:0]  rec_month;
    logic [REC_DATE_W-1:0]  rec_day;
    logic                   expired;
    logic                   short_ing;
    logic                   overflow;

    assign use_amt = '{use_black, use_green, use_milk, use_pine};

    assign rec_month = rec[REC_MONTH_LSB +: REC_DATE_W];
    assign rec_day   = rec[REC_DAY_LSB +: REC_DATE_W];

    // expiry day itself still counts as valid
    assign expired = (REC_DATE_W'(today_month) > rec_month) ||
                     (REC_DATE_W'(today_month) == rec_month &&
                      REC_DATE_W'(today_day) > rec_day);

    always_comb begin
        short_ing = 1'b0;
        overflow  = 1'b0;
        for (int i = 0; i < N_ING; i++) begin
            have_amt[i] = rec[ING_LSB[i] +: ING_W];
            sum_amt[i]  = {1'b0, have_amt[i]} + {1'b0, sup_amt[i]};
            short_ing   = short_ing | (have_amt[i] < use_amt[i]);
            overflow    = overflow | sum_amt[i][ING_W];   // carry means past 4095
        end
    end

    always_comb begin
        new_rec = rec;
        case (cur_act)
            ACT_MAKE: begin
                for (int i = 0; i < N_ING; i++)
                    new_rec[ING_LSB[i] +: ING_W] = have_amt[i] - use_amt[i];
            end
            ACT_SUPPLY: begin
                for (int i = 0; i < N_ING; i++)
                    new_rec[ING_LSB[i] +: ING_W] = sum_amt[i][ING_W] ? ING_MAX :
                                                   sum_amt[i][ING_W-1:0];
                new_rec[REC_MONTH_LSB +: REC_DATE_W] = REC_DATE_W'(today_month);
                new_rec[REC_DAY_LSB +: REC_DATE_W]   = REC_DATE_W'(today_day);
            end
            default: ;   // check leaves the record alone
        endcase
    end

    // make reports expiry before shortage
    always_comb begin
        result      = ERR_NONE;
        needs_write = 1'b0;
        case (cur_act)
            ACT_MAKE: begin
                if (expired)
                    result = ERR_EXPIRED;
                else if (short_ing)
                    result = ERR_NO_ING;
                else
                    needs_write = 1'b1;
            end
            ACT_SUPPLY: begin
                needs_write = 1'b1;   // written even on overflow
                if (overflow)
                    result = ERR_OVERFLOW;
            end
            ACT_CHECK: begin
                if (expired)
                    result = ERR_EXPIRED;
            end
            default: ;
        endcase
    end

endmodule

// File: design/bev_ctrl.sv
`timescale 1ns/100ps

module bev_ctrl import bev_pkg::*; (
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  sel_action_valid,
    input  logic                  box_no_valid,
    input  logic                  box_sup_valid,
    input  action_t               cur_act,
    input  logic [SUP_CNT_W-1:0]  sup_count,
    input  box_no_t               cur_box,
    input  logic                  c_out_valid,
    input  box_rec_t              c_data_r,
    input  box_rec_t              new_rec,
    input  err_t                  result,
    input  logic                  needs_write,
    output box_rec_t              rec,
    output logic                  c_in_valid,
    output logic                  c_r_wb,
    output box_no_t               c_addr,
    output box_rec_t              c_data_w,
    output logic                  out_valid,
    output logic                  complete,
    output err_t                  err_msg
);

    ctrl_state_t state;
    box_rec_t    rec_q;       // record as read
    logic        rd_start;    // last strobe of the transaction
    logic        rd_resp;     // read data on c_data_r this cycle
    logic        finish;

    // supply waits for its fourth amount, the others for the box number
    assign rd_start = (cur_act == ACT_SUPPLY) ?
                      (box_sup_valid && sup_count == SUP_CNT_W'(N_ING - 1)) :
                      box_no_valid;

    assign rd_resp = (state == S_READ) && c_out_valid;

    // read data goes straight to the evaluator in its response cycle
    assign rec = rd_resp ? c_data_r : rec_q;

    // box address is stable from the cycle after box_no until the next action
    assign c_addr = cur_box;

    // last memory response of the action
    assign finish = (rd_resp && !needs_write) || (state == S_WRITE && c_out_valid);

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state      <= S_IDLE;
            c_in_valid <= 1'b0;
            c_r_wb     <= 1'b0;
            out_valid  <= 1'b0;
            complete   <= 1'b0;
            err_msg    <= ERR_NONE;
        end else begin
            c_in_valid <= 1'b0;   // requests are one-cycle strobes
            out_valid  <= finish;
            complete   <= finish && (result == ERR_NONE);
            err_msg    <= finish ? result : ERR_NONE;

            case (state)
                S_IDLE: begin
                    if (sel_action_valid)
                        state <= S_COLLECT;
                end
                S_COLLECT: begin
                    if (rd_start) begin
                        state      <= S_READ;
                        c_in_valid <= 1'b1;
                        c_r_wb     <= 1'b1;   // read
                    end
                end
                S_READ: begin
                    if (c_out_valid && needs_write) begin
                        state      <= S_WRITE;
                        c_in_valid <= 1'b1;
                        c_r_wb     <= 1'b0;   // write back
                    end else if (c_out_valid) begin
                        state <= S_DONE;      // check, or make that failed
                    end
                end
                S_WRITE: begin
                    if (c_out_valid)
                        state <= S_DONE;
                end
                S_DONE: state <= sel_action_valid ? S_COLLECT : S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // record and write data taken in the read response cycle
    always_ff @(posedge clk) begin
        if (rd_resp) begin
            rec_q    <= c_data_r;
            c_data_w <= new_rec;
        end
    end

endmodule

// File: design/bev_top.sv
`timescale 1ns/100ps

module bev_top import bev_pkg::*; (
    input  logic      clk,
    input  logic      inf,
    input  logic      sel_action_valid,
    input  action_t   act,
    input  logic      type_valid,
    input  bev_type_t bev_type,
    input  logic      size_valid,
    input  bev_size_t bev_size,
    input  logic      date_valid,
    input  month_t    month,
    input  day_t      day,
    input  logic      box_no_valid,
    input  box_no_t   box_no,
    input  logic      box_sup_valid,
    input  ing_amt_t  ing,
    input  logic      c_out_valid,
    input  box_rec_t  c_data_r,
    output logic      out_valid,
    output logic      complete,
    output err_t      err_msg,
    output logic      c_in_valid,
    output logic      c_r_wb,
    output box_no_t   c_addr,
    output box_rec_t  c_data_w
);

    action_t               cur_act;
    bev_type_t             cur_type;
    bev_size_t             cur_size;
    month_t                today_month;
    day_t                  today_day;
    box_no_t               cur_box;
    ing_amt_t              sup_amt [N_ING];
    logic [SUP_CNT_W-1:0]  sup_count;
    ing_amt_t              use_black, use_green, use_milk, use_pine;
    box_rec_t              rec;      // record under evaluation
    box_rec_t              new_rec;
    err_t                  result;
    logic                  needs_write;

    bev_input_capture u_capture (
        .clk, .inf,
        .sel_action_valid, .act,
        .type_valid, .bev_type,
        .size_valid, .bev_size,
        .date_valid, .month, .day,
        .box_no_valid, .box_no,
        .box_sup_valid, .ing,
        .cur_act, .cur_type, .cur_size,
        .today_month, .today_day,
        .cur_box, .sup_amt, .sup_count
    );

    bev_recipe u_recipe (
        .cur_type, .cur_size,
        .use_black, .use_green, .use_milk, .use_pine
    );

    bev_record_eval u_eval (
        .rec, .cur_act, .today_month, .today_day, .sup_amt,
        .use_black, .use_green, .use_milk, .use_pine,
        .new_rec, .result, .needs_write
    );

    bev_ctrl u_ctrl (
        .clk, .inf,
        .sel_action_valid, .box_no_valid, .box_sup_valid,
        .cur_act, .sup_count, .cur_box,
        .c_out_valid, .c_data_r,
        .new_rec, .result, .needs_write,
        .rec, .c_in_valid, .c_r_wb, .c_addr, .c_data_w,
        .out_valid, .complete, .err_msg
    );

endmodule

// File: test/bev_checker.sv
`timescale 1ns/100ps

module bev_checker import bev_pkg::*; (
    input logic clk,
    input logic inf,
    input logic out_valid,
    input logic complete,
    input err_t err_msg,
    input logic c_in_valid,
    input logic c_out_valid
);

    int   fail_count = 0;   // summed into the testbench result
    logic req_open;         // request sent, response not yet back

    always_ff @(posedge clk or negedge inf) begin
        if (!inf)
            req_open <= 1'b0;
        else if (c_in_valid)
            req_open <= 1'b1;
        else if (c_out_valid)
            req_open <= 1'b0;
    end

    a_out_pulse: assert property (@(posedge clk) disable iff (!inf)
                                  out_valid |=> !out_valid)
        else begin
            $error("out_valid high for more than one cycle");
            fail_count++;
        end

    a_complete_ok: assert property (@(posedge clk) disable iff (!inf)
                                    complete |-> err_msg == ERR_NONE)
        else begin
            $error("complete with err_msg %0d", err_msg);
            fail_count++;
        end

    a_req_pulse: assert property (@(posedge clk) disable iff (!inf)
                                  c_in_valid |=> !c_in_valid)
        else begin
            $error("c_in_valid high for more than one cycle");
            fail_count++;
        end

    // one request in flight
    a_one_req: assert property (@(posedge clk) disable iff (!inf)
                                c_in_valid |-> !req_open)
        else begin
            $error("new c_in_valid before c_out_valid");
            fail_count++;
        end

endmodule

bind bev_top bev_checker u_checker (
    .clk         (clk),
    .inf         (inf),
    .out_valid   (out_valid),
    .complete    (complete),
    .err_msg     (err_msg),
    .c_in_valid  (c_in_valid),
    .c_out_valid (c_out_valid)
);

// File: test/bev_tb.sv
`timescale 1ns/100ps

module bev_tb import bev_pkg::*; ();

    logic       clk;
    logic       inf;
    logic       sel_action_valid;
    action_t    act;
    logic       type_valid;
    bev_type_t  bev_type;
    logic       size_valid;
    bev_size_t  bev_size;
    logic       date_valid;
    month_t     month;
    day_t       day;
    logic       box_no_valid;
    box_no_t    box_no;
    logic       box_sup_valid;
    ing_amt_t   ing;
    logic       c_out_valid;
    box_rec_t   c_data_r;
    logic       out_valid;
    logic       complete;
    err_t       err_msg;
    logic       c_in_valid;
    logic       c_r_wb;
    box_no_t    c_addr;
    box_rec_t   c_data_w;

    box_rec_t   mem [256];       // memory behind the DUT
    box_rec_t   ref_mem [256];   // reference model copy
    int         n_checks;
    int         n_errors;
    int         n_writes;        // write requests seen by the memory
    bit         timed_out;

    bev_top u_dut (.*);

    always #4 clk = ~clk;   // 8 ns period

    // ingredient shares in quarters as nibbles of black/green/milk/pine
    function automatic int drink_quarters(input bev_type_t t, input int i);
        logic [15:0] q;
        case (t)
            BEV_BLACK_TEA:           q = 16'h4000;
            BEV_MILK_TEA:            q = 16'h3010;
            BEV_EXTRA_MILK_TEA:      q = 16'h2020;
            BEV_GREEN_TEA:           q = 16'h0400;
            BEV_GREEN_MILK_TEA:      q = 16'h0220;
            BEV_PINE_JUICE:          q = 16'h0004;
            BEV_SUPER_PINE_TEA:      q = 16'h2002;
            default:                 q = 16'h2011;   // super pineapple milk tea
        endcase
        return q[15 - 4*i -: 4];
    endfunction

    function automatic int field_lsb(input int i);
        case (i)
            0:       return REC_BLACK_LSB;
            1:       return REC_GREEN_LSB;
            2:       return REC_MILK_LSB;
            default: return REC_PINE_LSB;
        endcase
    endfunction

    function automatic box_rec_t random_record();
        box_rec_t r;
        r = '0;
        for (int i = 0; i < 4; i++)
            r[field_lsb(i) +: 12] = 12'($urandom_range(0, 4095));
        r[REC_MONTH_LSB +: 8] = 8'($urandom_range(1, 12));
        r[REC_DAY_LSB +: 8]   = 8'($urandom_range(1, 28));
        return r;
    endfunction

    function automatic bev_size_t random_size();
        case ($urandom_range(0, 2))
            0:       return SIZE_L;
            1:       return SIZE_M;
            default: return SIZE_S;
        endcase
    endfunction

    // applies one action to ref_mem and returns the expected error and write
    function automatic void model_action(input action_t a, input box_no_t box,
                                         input month_t m, input day_t d,
                                         input bev_type_t t, input bev_size_t s,
                                         input logic [47:0] sup,
                                         output err_t e, output logic wr);
        box_rec_t r;
        box_rec_t made;
        box_rec_t supplied;
        int       vol;
        int       have;
        int       used;
        int       sum;
        logic     expired;
        logic     short_ing;
        logic     ovf;
        r        = ref_mem[box];
        made     = r;
        supplied = r;
        expired  = (m > r[REC_MONTH_LSB +: 8]) ||
                   (m == r[REC_MONTH_LSB +: 8] && d > r[REC_DAY_LSB +: 8]);
        vol = (s == SIZE_L) ? VOL_L : (s == SIZE_M) ? VOL_M : VOL_S;
        short_ing = 1'b0;
        ovf       = 1'b0;
        for (int i = 0; i < 4; i++) begin
            have = r[field_lsb(i) +: 12];
            used = vol * drink_quarters(t, i) / 4;
            sum  = have + sup[47 - 12*i -: 12];
            short_ing |= (have < used);
            ovf       |= (sum > 4095);
            made[field_lsb(i) +: 12]     = 12'(have - used);
            supplied[field_lsb(i) +: 12] = (sum > 4095) ? 12'd4095 : 12'(sum);   // saturate
        end
        supplied[REC_MONTH_LSB +: 8] = 8'(m);
        supplied[REC_DAY_LSB +: 8]   = 8'(d);
        e  = ERR_NONE;
        wr = 1'b0;
        case (a)
            ACT_MAKE: begin
                if (expired)
                    e = ERR_EXPIRED;
                else if (short_ing)
                    e = ERR_NO_ING;
                else begin
                    wr = 1'b1;
                    ref_mem[box] = made;
                end
            end
            ACT_SUPPLY: begin
                wr = 1'b1;   // written even when a sum saturates
                ref_mem[box] = supplied;
                if (ovf)
                    e = ERR_OVERFLOW;
            end
            default: begin
                if (expired)
                    e = ERR_EXPIRED;
            end
        endcase
    endfunction

    // memory model answers one request at a time after 1 to 6 cycles
    task automatic serve_request();
        logic     rd;
        box_no_t  addr;
        box_rec_t wdata;
        int       delay;
        rd    = c_r_wb;
        addr  = c_addr;
        wdata = c_data_w;
        delay = $urandom_range(1, 6);
        if (!rd)
            n_writes++;
        repeat (delay - 1) @(posedge clk);
        c_out_valid <= 1'b1;
        if (rd)
            c_data_r <= mem[addr];
        else
            mem[addr] = wdata;
        @(posedge clk);
        c_out_valid <= 1'b0;
    endtask

    always begin
        @(posedge clk);
        if (c_in_valid)
            serve_request();
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // moves to the next edge and drops every strobe
    task automatic next_strobe_cycle();
        @(posedge clk);
        sel_action_valid <= 1'b0;
        type_valid       <= 1'b0;
        size_valid       <= 1'b0;
        date_valid       <= 1'b0;
        box_no_valid     <= 1'b0;
        box_sup_valid    <= 1'b0;
    endtask

    task automatic wait_result(output err_t got_err, output logic got_complete);
        got_err      = ERR_NONE;
        got_complete = 1'b0;
        for (int cycles = 0; cycles < 200; cycles++) begin
            @(posedge clk);
            if (out_valid) begin
                got_err      = err_msg;
                got_complete = complete;
                return;
            end
        end
        timed_out = 1'b1;
        n_errors++;
        $display("out_valid did not arrive within 200 cycles, stopped at %0t ns", $time);
    endtask

    task automatic do_action(input action_t a, input box_no_t box, input month_t m,
                             input day_t d, input bev_type_t t, input bev_size_t s,
                             input logic [47:0] sup);
        err_t exp_err;
        logic exp_wr;
        err_t got_err;
        logic got_complete;
        int   writes_before;
        model_action(a, box, m, d, t, s, sup, exp_err, exp_wr);
        writes_before = n_writes;
        next_strobe_cycle();
        sel_action_valid <= 1'b1;
        act              <= a;
        if (a == ACT_MAKE) begin
            next_strobe_cycle();
            type_valid <= 1'b1;
            bev_type   <= t;
            next_strobe_cycle();
            size_valid <= 1'b1;
            bev_size   <= s;
        end
        next_strobe_cycle();
        date_valid <= 1'b1;
        month      <= m;
        day        <= d;
        next_strobe_cycle();
        box_no_valid <= 1'b1;
        box_no       <= box;
        if (a == ACT_SUPPLY) begin
            for (int i = 0; i < 4; i++) begin   // black, green, milk, pine
                next_strobe_cycle();
                box_sup_valid <= 1'b1;
                ing           <= sup[47 - 12*i -: 12];
            end
        end
        next_strobe_cycle();
        wait_result(got_err, got_complete);
        if (timed_out)
            return;
        check_value("err_msg", got_err, exp_err);
        check_value("complete", got_complete, exp_err == ERR_NONE);
        check_value("write requests", n_writes - writes_before, exp_wr);
        check_value($sformatf("mem[%0d]", box), mem[box], ref_mem[box]);
    endtask

    task automatic random_action(input action_t a);
        logic [47:0] sup;
        for (int k = 0; k < 4; k++) begin
            if ($urandom_range(0, 3) == 0)
                sup[47 - 12*k -: 12] = 12'($urandom_range(3900, 4095));   // near full
            else
                sup[47 - 12*k -: 12] = 12'($urandom_range(0, 2000));
        end
        do_action(a, box_no_t'($urandom_range(0, 255)), month_t'($urandom_range(1, 12)),
                  day_t'($urandom_range(1, 28)), bev_type_t'($urandom_range(0, 7)),
                  random_size(), sup);
    endtask

    // kind is an action code, or 3 for a mix of all three
    task automatic run_test(input string name, input int kind, input int count);
        int start_err;
        start_err = n_errors;
        for (int i = 0; i < count && !timed_out; i++) begin
            if (kind == 3)
                random_action(action_t'($urandom_range(0, 2)));
            else
                random_action(action_t'(kind));
        end
        $display("%-8s %0d actions, %0d errors", name, count, n_errors - start_err);
    endtask

    initial begin
        int total;
        clk              = 1'b0;
        inf              = 1'b0;
        sel_action_valid = 1'b0;
        type_valid       = 1'b0;
        size_valid       = 1'b0;
        date_valid       = 1'b0;
        box_no_valid     = 1'b0;
        box_sup_valid    = 1'b0;
        act              = ACT_MAKE;
        bev_type         = BEV_BLACK_TEA;
        bev_size         = SIZE_L;
        month            = '0;
        day              = '0;
        box_no           = '0;
        ing              = '0;
        c_out_valid      = 1'b0;
        c_data_r         = '0;
        n_checks         = 0;
        n_errors         = 0;
        n_writes         = 0;
        timed_out        = 1'b0;
        void'($urandom(32'h6c195820));
        for (int i = 0; i < 256; i++) begin
            mem[i]     = random_record();
            ref_mem[i] = mem[i];
        end
        repeat (3) @(posedge clk);
        inf <= 1'b1;
        @(posedge clk);
        check_value("out_valid", out_valid, 1'b0);
        check_value("complete", complete, 1'b0);
        check_value("err_msg", err_msg, ERR_NONE);
        check_value("c_in_valid", c_in_valid, 1'b0);
        check_value("c_r_wb", c_r_wb, 1'b0);
        $display("%-8s %0d errors", "reset", n_errors);
        run_test("check", ACT_CHECK, 40);
        run_test("make", ACT_MAKE, 60);
        run_test("supply", ACT_SUPPLY, 60);
        run_test("mixed", 3, 200);
        if (!timed_out) begin
            for (int i = 0; i < 256; i++)
                check_value($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
        end
        total = n_errors + u_dut.u_checker.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures", n_checks, n_errors,
                 u_dut.u_checker.fail_count);
        if (total == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: src.f
common/bev_pkg.sv
design/bev_input_capture.sv
design/bev_recipe.sv
design/bev_record_eval.sv
design/bev_ctrl.sv
design/bev_top.sv
test/bev_checker.sv
test/bev_tb.sv

// File: Bender.yml
package:
  name: bev_machine

sources:
  - common/bev_pkg.sv
  - design/bev_input_capture.sv
  - design/bev_recipe.sv
  - design/bev_record_eval.sv
  - design/bev_ctrl.sv
  - design/bev_top.sv
  - target: test
    files:
      - test/bev_checker.sv
      - test/bev_tb.sv
